//--- hdl/cce_pkg.sv
package cce_pkg;

  // address and id widths
  localparam int paddr_width  = 28;
  localparam int lce_id_width = 4;
  localparam int cce_id_width = 4;

  // request opcode field in the packed header
  localparam int msg_width = 2;

  // packed header is {msg, addr, lce_id, cce_id}
  localparam int header_width = msg_width + paddr_width + lce_id_width + cce_id_width;

  // header buffer depth
  localparam int header_els = 2;

  // LCE request opcodes
  typedef enum logic [msg_width-1:0] {
    e_req_rd
    , e_req_wr
    , e_req_uc_rd  // uncached read
    , e_req_uc_wr  // uncached write
  } req_msg_e;

  // memory command opcodes
  typedef enum logic {
    e_mem_rd
    , e_mem_wr
  } mem_cmd_e;

  // engine operating mode
  typedef enum logic {
    e_cce_mode_normal
    , e_cce_mode_uncached  // only uc requests allowed
  } cce_mode_e;

endpackage

//--- hdl/cce_header_fifo.sv
`timescale 1ns/1ns

module cce_header_fifo #(
  parameter int width_p = 8
) (
  input                      clk_i,
  input                      reset_i,

  // enqueue side
  input                      v_i,
  input        [width_p-1:0] data_i,
  output logic               ready_o,

  // dequeue side
  output logic               v_o,
  output logic [width_p-1:0] data_o,
  input                      yumi_i
);

  localparam int els       = cce_pkg::header_els;
  localparam int ptr_width = (els > 1) ? $clog2(els) : 1;

  logic [width_p-1:0]   mem_r [els];
  logic [ptr_width-1:0] rd_ptr_r, wr_ptr_r;
  logic                 last_wr_r;  // last pointer move was a write
  logic                 enq, deq;
  logic                 ptr_equal;

  assign ptr_equal = (rd_ptr_r == wr_ptr_r);

  // equal pointers are full after a write, empty after a read
  assign ready_o = ~(ptr_equal & last_wr_r);
  assign v_o     = ~(ptr_equal & ~last_wr_r);

  assign enq = v_i & ready_o;
  assign deq = yumi_i;

  assign data_o = mem_r[rd_ptr_r];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_ptr_r  <= '0;
      wr_ptr_r  <= '0;
      last_wr_r <= 1'b0;
    end else begin
      if (enq) begin
        wr_ptr_r <= (wr_ptr_r == ptr_width'(els - 1)) ? '0 : wr_ptr_r + 1'b1;
      end
      if (deq) begin
        rd_ptr_r <= (rd_ptr_r == ptr_width'(els - 1)) ? '0 : rd_ptr_r + 1'b1;
      end
      if (enq & ~deq) begin
        last_wr_r <= 1'b1;
      end else if (deq & ~enq) begin
        last_wr_r <= 1'b0;
      end
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (enq) begin
      mem_r[wr_ptr_r] <= data_i;
    end
  end

endmodule

//--- hdl/cce_prog_pipe.sv
`timescale 1ns/1ns

module cce_prog_pipe (
  input                                   clk_i,
  input                                   reset_i,

  // control
  input  cce_pkg::cce_mode_e              cce_mode_i,
  input  [cce_pkg::cce_id_width-1:0]      cce_id_i,

  // header buffer head
  input                                   hdr_v_i,
  input  cce_pkg::req_msg_e               hdr_msg_i,
  input  [cce_pkg::cce_id_width-1:0]      hdr_cce_id_i,
  output logic                            hdr_yumi_o,

  // status to coherent pipe
  output logic                            prog_v_o,
  output logic                            prog_status_o,  // 1 = okay, 0 = squash
  output logic                            empty_o,
  input                                   prog_yumi_i
);

  typedef enum logic [1:0] {
    e_reset
    , e_ready
    , e_send_status
  } state_e;

  state_e state_r, state_n;

  logic status_r, status_n;
  logic id_miss;
  logic cached_req;
  logic squash;

  // judge the head request
  assign id_miss    = (hdr_cce_id_i != cce_id_i);
  assign cached_req = (hdr_msg_i == cce_pkg::e_req_rd) | (hdr_msg_i == cce_pkg::e_req_wr);
  assign squash     = id_miss | ((cce_mode_i == cce_pkg::e_cce_mode_uncached) & cached_req);

  always_comb begin
    state_n    = state_r;
    status_n   = status_r;
    hdr_yumi_o = 1'b0;
    prog_v_o   = 1'b0;

    case (state_r)
      e_reset: begin
        state_n = e_ready;
      end

      e_ready: begin
        hdr_yumi_o = hdr_v_i;  // take head as soon as it shows
        if (hdr_v_i) begin
          status_n = ~squash;
          state_n  = e_send_status;
        end
      end

      e_send_status: begin
        prog_v_o = 1'b1;
        if (prog_yumi_i) begin
          state_n = e_ready;
        end
      end

      default: begin
        state_n = e_reset;
      end
    endcase
  end

  assign prog_status_o = status_r;

  // nothing buffered and nothing pending
  assign empty_o = ~hdr_v_i & (state_r != e_send_status);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_reset;
    end else begin
      state_r <= state_n;
    end
  end

  always_ff @(posedge clk_i) begin
    status_r <= status_n;
  end

endmodule

//--- hdl/cce_coh_pipe.sv
`timescale 1ns/1ns

module cce_coh_pipe (
  input                                   clk_i,
  input                                   reset_i,

  // header buffer head
  input                                   hdr_v_i,
  input  cce_pkg::req_msg_e               hdr_msg_i,
  input  [cce_pkg::paddr_width-1:0]       hdr_addr_i,
  input  [cce_pkg::lce_id_width-1:0]      hdr_lce_id_i,
  output logic                            hdr_yumi_o,

  // status from programmable pipe
  input                                   prog_v_i,
  input                                   prog_status_i,
  output logic                            prog_yumi_o,
  input                                   prog_empty_i,

  // memory command
  output logic                            mem_cmd_v_o,
  output cce_pkg::mem_cmd_e               mem_cmd_msg_o,
  output logic [cce_pkg::paddr_width-1:0] mem_cmd_addr_o,
  output logic [cce_pkg::lce_id_width-1:0] mem_cmd_lce_id_o,
  input                                   mem_cmd_yumi_i,

  output logic                            empty_o
);

  typedef enum logic {
    e_ready
    , e_send_cmd
  } state_e;

  state_e state_r, state_n;

  cce_pkg::mem_cmd_e                msg_r, msg_n;
  logic [cce_pkg::paddr_width-1:0]  addr_r, addr_n;
  logic [cce_pkg::lce_id_width-1:0] lce_id_r, lce_id_n;
  cce_pkg::mem_cmd_e                mem_op;
  logic                             pair_v;

  // header and its status are taken together
  assign pair_v = hdr_v_i & prog_v_i;

  // request opcode to memory opcode
  always_comb begin
    case (hdr_msg_i)
      cce_pkg::e_req_rd,
      cce_pkg::e_req_uc_rd: mem_op = cce_pkg::e_mem_rd;
      default:              mem_op = cce_pkg::e_mem_wr;
    endcase
  end

  always_comb begin
    state_n     = state_r;
    msg_n       = msg_r;
    addr_n      = addr_r;
    lce_id_n    = lce_id_r;
    hdr_yumi_o  = 1'b0;
    prog_yumi_o = 1'b0;
    mem_cmd_v_o = 1'b0;

    case (state_r)
      e_ready: begin
        hdr_yumi_o  = pair_v;
        prog_yumi_o = pair_v;
        if (pair_v & prog_status_i) begin
          msg_n    = mem_op;
          addr_n   = hdr_addr_i;
          lce_id_n = hdr_lce_id_i;
          state_n  = e_send_cmd;
        end
        // squashed request is simply dropped
      end

      e_send_cmd: begin
        mem_cmd_v_o = 1'b1;
        if (mem_cmd_yumi_i) begin
          state_n = e_ready;
        end
      end

      default: begin
        state_n = e_ready;
      end
    endcase
  end

  assign mem_cmd_msg_o    = msg_r;
  assign mem_cmd_addr_o   = addr_r;
  assign mem_cmd_lce_id_o = lce_id_r;

  // idle here and upstream
  assign empty_o = (state_r == e_ready) & ~hdr_v_i & prog_empty_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_ready;
    end else begin
      state_r <= state_n;
    end
  end

  // command fields, held while waiting on yumi
  always_ff @(posedge clk_i) begin
    msg_r    <= msg_n;
    addr_r   <= addr_n;
    lce_id_r <= lce_id_n;
  end

endmodule

//--- hdl/cce_hybrid.sv
`timescale 1ns/1ns

module cce_hybrid (
  input                                    clk_i,
  input                                    reset_i,

  // control
  input  cce_pkg::cce_mode_e               cce_mode_i,
  input  [cce_pkg::cce_id_width-1:0]       cce_id_i,

  // LCE request header
  input                                    lce_req_v_i,
  input  cce_pkg::req_msg_e                lce_req_msg_i,
  input  [cce_pkg::paddr_width-1:0]        lce_req_addr_i,
  input  [cce_pkg::lce_id_width-1:0]       lce_req_lce_id_i,
  input  [cce_pkg::cce_id_width-1:0]       lce_req_cce_id_i,
  output logic                             lce_req_ready_and_o,

  // memory command
  output logic                             mem_cmd_v_o,
  output cce_pkg::mem_cmd_e                mem_cmd_msg_o,
  output logic [cce_pkg::paddr_width-1:0]  mem_cmd_addr_o,
  output logic [cce_pkg::lce_id_width-1:0] mem_cmd_lce_id_o,
  input                                    mem_cmd_yumi_i,

  output logic                             empty_o
);

  // field offsets in the packed header
  localparam int cce_id_lsb = 0;
  localparam int lce_id_lsb = cce_id_lsb + cce_pkg::cce_id_width;
  localparam int addr_lsb   = lce_id_lsb + cce_pkg::lce_id_width;
  localparam int msg_lsb    = addr_lsb + cce_pkg::paddr_width;

  logic [cce_pkg::header_width-1:0] req_hdr;
  logic [cce_pkg::header_width-1:0] prog_hdr, coh_hdr;
  logic                             req_fire;
  logic                             prog_buf_ready, coh_buf_ready;
  logic                             prog_hdr_v, prog_hdr_yumi;
  logic                             coh_hdr_v, coh_hdr_yumi;
  logic                             prog_v, prog_status, prog_yumi, prog_empty;
  cce_pkg::req_msg_e                prog_hdr_msg, coh_hdr_msg;

  assign req_hdr = {lce_req_msg_i, lce_req_addr_i, lce_req_lce_id_i, lce_req_cce_id_i};

  // both copies written on the same transfer
  assign lce_req_ready_and_o = prog_buf_ready & coh_buf_ready;
  assign req_fire            = lce_req_v_i & lce_req_ready_and_o;

  cce_header_fifo #(.width_p(cce_pkg::header_width)) prog_hdr_buf (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .v_i     (req_fire),
    .data_i  (req_hdr),
    .ready_o (prog_buf_ready),
    .v_o     (prog_hdr_v),
    .data_o  (prog_hdr),
    .yumi_i  (prog_hdr_yumi)
  );

  cce_header_fifo #(.width_p(cce_pkg::header_width)) coh_hdr_buf (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .v_i     (req_fire),
    .data_i  (req_hdr),
    .ready_o (coh_buf_ready),
    .v_o     (coh_hdr_v),
    .data_o  (coh_hdr),
    .yumi_i  (coh_hdr_yumi)
  );

  assign prog_hdr_msg = cce_pkg::req_msg_e'(prog_hdr[msg_lsb +: cce_pkg::msg_width]);
  assign coh_hdr_msg  = cce_pkg::req_msg_e'(coh_hdr[msg_lsb +: cce_pkg::msg_width]);

  cce_prog_pipe u_prog_pipe (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .cce_mode_i    (cce_mode_i),
    .cce_id_i      (cce_id_i),
    .hdr_v_i       (prog_hdr_v),
    .hdr_msg_i     (prog_hdr_msg),
    .hdr_cce_id_i  (prog_hdr[cce_id_lsb +: cce_pkg::cce_id_width]),
    .hdr_yumi_o    (prog_hdr_yumi),
    .prog_v_o      (prog_v),
    .prog_status_o (prog_status),
    .empty_o       (prog_empty),
    .prog_yumi_i   (prog_yumi)
  );

  cce_coh_pipe u_coh_pipe (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .hdr_v_i          (coh_hdr_v),
    .hdr_msg_i        (coh_hdr_msg),
    .hdr_addr_i       (coh_hdr[addr_lsb +: cce_pkg::paddr_width]),
    .hdr_lce_id_i     (coh_hdr[lce_id_lsb +: cce_pkg::lce_id_width]),
    .hdr_yumi_o       (coh_hdr_yumi),
    .prog_v_i         (prog_v),
    .prog_status_i    (prog_status),
    .prog_yumi_o      (prog_yumi),
    .prog_empty_i     (prog_empty),
    .mem_cmd_v_o      (mem_cmd_v_o),
    .mem_cmd_msg_o    (mem_cmd_msg_o),
    .mem_cmd_addr_o   (mem_cmd_addr_o),
    .mem_cmd_lce_id_o (mem_cmd_lce_id_o),
    .mem_cmd_yumi_i   (mem_cmd_yumi_i),
    .empty_o          (empty_o)  // covers the prog pipe too
  );

endmodule

//--- sim/tb_cce_hybrid.sv
`timescale 1ns/1ns

module tb_cce_hybrid;

  localparam logic [cce_pkg::cce_id_width-1:0] own_cce_id = 4'h5;
  localparam int num_reqs    = 8 + 8 + 8 + 6 + 40;
  localparam int cycle_limit = 40 * num_reqs + 200;
  localparam int yumi_hold   = 0;
  localparam int yumi_always = 1;
  localparam int yumi_random = 2;

  typedef struct packed {
    cce_pkg::mem_cmd_e                msg;
    logic [cce_pkg::paddr_width-1:0]  addr;
    logic [cce_pkg::lce_id_width-1:0] lce_id;
  } mem_cmd_t;

  logic                             clk_i, reset_i;
  cce_pkg::cce_mode_e               cce_mode_i;
  logic [cce_pkg::cce_id_width-1:0] cce_id_i;
  logic                             lce_req_v_i, lce_req_ready_and_o;
  cce_pkg::req_msg_e                lce_req_msg_i;
  logic [cce_pkg::paddr_width-1:0]  lce_req_addr_i;
  logic [cce_pkg::lce_id_width-1:0] lce_req_lce_id_i;
  logic [cce_pkg::cce_id_width-1:0] lce_req_cce_id_i;
  logic                             mem_cmd_v_o, mem_cmd_yumi_i, empty_o;
  cce_pkg::mem_cmd_e                mem_cmd_msg_o;
  logic [cce_pkg::paddr_width-1:0]  mem_cmd_addr_o;
  logic [cce_pkg::lce_id_width-1:0] mem_cmd_lce_id_o;

  mem_cmd_t    exp_q[$];
  mem_cmd_t    exp_cmd;
  logic        exp_avail;
  int          errors, checked, cycles, yumi_mode;
  logic        saw_stall;
  logic [31:0] stim_lfsr, yumi_lfsr;

  cce_hybrid u_cce_hybrid (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // taps 32,22,2,1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      stim_lfsr = lfsr_next(stim_lfsr);
      val = {val[30:0], stim_lfsr[0]};
    end
  endtask

  task automatic refresh_expect();
    exp_avail = (exp_q.size() != 0);
    if (exp_avail) exp_cmd = exp_q[0];
  endtask

  // squash rule and opcode mapping of the engine
  task automatic model_req(input cce_pkg::req_msg_e msg, input logic [27:0] addr,
                           input logic [3:0] lce, input logic [3:0] cce);
    logic     squash;
    mem_cmd_t cmd;
    squash = (cce != cce_id_i) ||
             (cce_mode_i == cce_pkg::e_cce_mode_uncached &&
              (msg == cce_pkg::e_req_rd || msg == cce_pkg::e_req_wr));
    cmd.msg    = (msg == cce_pkg::e_req_rd || msg == cce_pkg::e_req_uc_rd) ?
                 cce_pkg::e_mem_rd : cce_pkg::e_mem_wr;
    cmd.addr   = addr;
    cmd.lce_id = lce;
    if (!squash) exp_q.push_back(cmd);
    refresh_expect();
  endtask

  task automatic send_req(input cce_pkg::req_msg_e msg, input logic [27:0] addr,
                          input logic [3:0] lce, input logic [3:0] cce);
    @(negedge clk_i);
    lce_req_v_i      = 1'b1;
    lce_req_msg_i    = msg;
    lce_req_addr_i   = addr;
    lce_req_lce_id_i = lce;
    lce_req_cce_id_i = cce;
    // ready only moves on a rising edge
    while (!lce_req_ready_and_o) begin
      saw_stall = 1'b1;
      @(negedge clk_i);
    end
    model_req(msg, addr, lce, cce);
  endtask

  task automatic idle_req();
    @(negedge clk_i);
    lce_req_v_i = 1'b0;
  endtask

  // engine idle, nothing buffered or pending
  task automatic drain();
    while (!empty_o) @(negedge clk_i);
  endtask

  task automatic set_yumi_mode(input int m);
    @(posedge clk_i);
    yumi_mode = m;
  endtask

  task automatic send_random(input int n);
    logic [31:0] r_msg, r_addr, r_lce, r_hit, r_id;
    for (int i = 0; i < n; i++) begin
      rand_bits(2, r_msg);
      rand_bits(28, r_addr);
      rand_bits(4, r_lce);
      rand_bits(2, r_hit);
      rand_bits(3, r_id);
      send_req(cce_pkg::req_msg_e'(r_msg[1:0]), r_addr[27:0], r_lce[3:0],
               (r_hit != 0) ? own_cce_id : own_cce_id ^ {r_id[2:0], 1'b1});
    end
    idle_req();
  endtask

  // memory side, yumi only while valid
  always @(negedge clk_i) begin
    case (yumi_mode)
      yumi_always: mem_cmd_yumi_i = mem_cmd_v_o;
      yumi_random: begin
        yumi_lfsr      = lfsr_next(yumi_lfsr);
        mem_cmd_yumi_i = mem_cmd_v_o & yumi_lfsr[0];
      end
      default:     mem_cmd_yumi_i = 1'b0;
    endcase
  end

  always @(posedge clk_i) begin
    if (!reset_i && mem_cmd_v_o && mem_cmd_yumi_i && exp_q.size() != 0) begin
      exp_q.delete(0);
      checked++;
      refresh_expect();
    end
  end

  cmd_match: assert property (@(posedge clk_i) disable iff (reset_i)
    (mem_cmd_v_o && mem_cmd_yumi_i && exp_avail) |->
      (mem_cmd_msg_o == exp_cmd.msg && mem_cmd_addr_o == exp_cmd.addr &&
       mem_cmd_lce_id_o == exp_cmd.lce_id))
  else begin
    errors++;
    $display("Mismatch at %0t: got msg %0d addr %h lce %0d, expected msg %0d addr %h lce %0d",
             $time, $sampled(mem_cmd_msg_o), $sampled(mem_cmd_addr_o),
             $sampled(mem_cmd_lce_id_o), $sampled(exp_cmd.msg), $sampled(exp_cmd.addr),
             $sampled(exp_cmd.lce_id));
  end

  cmd_expected: assert property (@(posedge clk_i) disable iff (reset_i)
    (mem_cmd_v_o && mem_cmd_yumi_i) |-> exp_avail)
  else begin
    errors++;
    $display("memory command issued at %0t when none was expected", $time);
  end

  // command held steady under back-pressure
  cmd_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    (mem_cmd_v_o && !mem_cmd_yumi_i) |=>
      (mem_cmd_v_o && $stable(mem_cmd_msg_o) && $stable(mem_cmd_addr_o) &&
       $stable(mem_cmd_lce_id_o)))
  else begin
    errors++;
    $display("Mismatch at %0t: memory command changed before yumi", $time);
  end

  initial begin
    cycles = 0;
    while (cycles < cycle_limit) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("timeout after %0d cycles, traffic did not drain", cycles);
    $display("closing: %0d errors, %0d commands checked", errors, checked);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    reset_i          = 1'b1;
    cce_mode_i       = cce_pkg::e_cce_mode_normal;
    cce_id_i         = own_cce_id;
    lce_req_v_i      = 1'b0;
    lce_req_msg_i    = cce_pkg::e_req_rd;
    lce_req_addr_i   = '0;
    lce_req_lce_id_i = '0;
    lce_req_cce_id_i = '0;
    mem_cmd_yumi_i   = 1'b0;
    yumi_mode        = yumi_always;
    errors           = 0;
    checked          = 0;
    saw_stall        = 1'b0;
    exp_avail        = 1'b0;
    exp_cmd          = '0;
    stim_lfsr        = 32'h364c;
    yumi_lfsr        = 32'h364c;

    repeat (5) @(negedge clk_i);
    reset_i = 1'b0;
    @(negedge clk_i);
    assert (!mem_cmd_v_o && empty_o && lce_req_ready_and_o) else begin
      errors++;
      $display("DUT not idle after reset");
    end

    // every opcode, matching id
    for (int i = 0; i < 8; i++) begin
      send_req(cce_pkg::req_msg_e'(i % 4), 28'h0100 + 28'(i * 64), 4'(i), own_cce_id);
    end
    idle_req();
    drain();

    // wrong destination mixed with good ones
    for (int i = 0; i < 8; i++) begin
      send_req(cce_pkg::req_msg_e'(i % 4), 28'h0a000 + 28'(i), 4'(15 - i),
               (i % 3 == 0) ? own_cce_id : own_cce_id ^ 4'(i + 1));
    end
    idle_req();
    drain();

    @(negedge clk_i);
    cce_mode_i = cce_pkg::e_cce_mode_uncached;
    for (int i = 0; i < 8; i++) begin
      send_req(cce_pkg::req_msg_e'((i + 1) % 4), 28'h0fff000 + 28'(i * 8), 4'(i + 3),
               own_cce_id);
    end
    idle_req();
    drain();
    @(negedge clk_i);
    cce_mode_i = cce_pkg::e_cce_mode_normal;

    // memory held off until the buffers fill
    set_yumi_mode(yumi_hold);
    saw_stall = 1'b0;
    fork
      begin
        for (int i = 0; i < 6; i++) begin
          send_req(cce_pkg::req_msg_e'(i % 2), 28'h0333000 + 28'(i), 4'(i), own_cce_id);
        end
        idle_req();
      end
      begin
        repeat (20) @(posedge clk_i);
        yumi_mode = yumi_random;
      end
    join
    drain();
    assert (saw_stall) else begin
      errors++;
      $display("ready_and never dropped while memory commands were held off");
    end

    send_random(40);
    drain();
    repeat (3) @(negedge clk_i);

    assert (exp_q.size() == 0) else begin
      errors++;
      $display("%0d expected commands never issued", exp_q.size());
    end
    assert (empty_o) else begin
      errors++;
      $display("empty_o low after traffic drained");
    end

    $display("closing: %0d errors, %0d commands checked", errors, checked);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- cce_hybrid.f
hdl/cce_pkg.sv
hdl/cce_header_fifo.sv
hdl/cce_prog_pipe.sv
hdl/cce_coh_pipe.sv
hdl/cce_hybrid.sv
sim/tb_cce_hybrid.sv

//--- Bender.yml
package:
  name: cce_hybrid

sources:
  - hdl/cce_pkg.sv
  - hdl/cce_header_fifo.sv
  - hdl/cce_prog_pipe.sv
  - hdl/cce_coh_pipe.sv
  - hdl/cce_hybrid.sv
  - target: simulation
    files:
      - sim/tb_cce_hybrid.sv
